// File: cl_pkg.sv
// Shared types and constants for the CL control and status shell
// Channel count, register words, scrub engine state and scrub region
package cl_pkg;

  // --------------------------------------------------
  // Sizes and words
  // --------------------------------------------------
  localparam int NUM_DDR = 4;

  typedef logic [NUM_DDR-1:0] ch_vec_t;
  typedef logic [31:0]        ctl_word_t;
  typedef logic [31:0]        status_word_t;
  typedef logic [63:0]        scrb_addr_t;

  // --------------------------------------------------
  // Scrub engine
  // --------------------------------------------------
  typedef enum logic [2:0] {
    SCRB_IDLE = 3'd0,
    SCRB_RUN  = 3'd1,
    SCRB_GAP  = 3'd2,
    SCRB_DONE = 3'd3
  } scrb_state_t;

  // One 64-byte beat per cycle, bursts of 16 beats
  localparam scrb_addr_t SCRB_BEAT_BYTES  = 64'd64;
  localparam int         SCRB_BURST_BEATS = 16;

  // Simulation-sized region, 8 KB
  localparam scrb_addr_t SCRB_END_ADDR = 64'h2000;

  // --------------------------------------------------
  // Control register fields
  // --------------------------------------------------
  localparam int CTL_DBG_EN_BIT = 31;
  localparam int CTL_DBG_SEL_HI = 30;
  localparam int CTL_DBG_SEL_LO = 28;

  // --------------------------------------------------
  // Status and ID values
  // --------------------------------------------------
  localparam logic [19:0]  STATUS_SIG = 20'hA1111;
  localparam status_word_t ID0_VALUE  = 32'h1D50_6789;
  localparam status_word_t ID1_VALUE  = 32'h1D51_FEDC;

endpackage

// File: scrub_engine.sv
// Scrub address walker for one DDR channel
// Steps through the scrub region in 16-beat bursts with one gap cycle
// between bursts, and stalls while the channel is not ready
module scrub_engine (
  input  logic                clk,
  input  logic                sync_rst_n,
  input  logic                enable,
  input  logic                ddr_ready,
  output cl_pkg::scrb_state_t state,
  output cl_pkg::scrb_addr_t  addr,
  output logic                done
);

  import cl_pkg::*;

  localparam int BEAT_CNT_W = $clog2(SCRB_BURST_BEATS);
  localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(SCRB_BURST_BEATS - 1);

  logic [BEAT_CNT_W-1:0] beat_cnt;
  scrb_addr_t            addr_next;
  logic                  last_beat;
  logic                  end_reached;

  assign addr_next   = addr + SCRB_BEAT_BYTES;
  assign last_beat   = (beat_cnt == LAST_BEAT);
  assign end_reached = (addr_next == SCRB_END_ADDR);

  // --------------------------------------------------
  // State machine, address and beat counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      state    <= SCRB_IDLE;
      addr     <= '0;
      beat_cnt <= '0;
    end
    else if (!enable)
    begin
      // Dropping the enable restarts the channel from zero
      state    <= SCRB_IDLE;
      addr     <= '0;
      beat_cnt <= '0;
    end
    else
    begin
      case (state)
        SCRB_IDLE:
        begin
          state    <= SCRB_RUN;
          addr     <= '0;
          beat_cnt <= '0;
        end
        SCRB_RUN:
        begin
          if (ddr_ready)
          begin
            addr     <= addr_next;
            beat_cnt <= beat_cnt + 1'b1;
            if (end_reached)
              state <= SCRB_DONE;
            else if (last_beat)
              state <= SCRB_GAP;
          end
        end
        SCRB_GAP:
          state <= SCRB_RUN;
        SCRB_DONE:
          state <= SCRB_DONE;
        default:
          state <= SCRB_IDLE;
      endcase
    end
  end

  assign done = (state == SCRB_DONE);

endmodule

// File: ctrl_status.sv
// Control register, status and ID word assembly for the CL shell
// Captures ctl0 and the DDR ready levels, drives the scrub enables,
// builds the normal or debug status and ID words, and answers FLR
module ctrl_status (
  input  logic                                      clk,
  input  logic                                      sync_rst_n,
  input  cl_pkg::ctl_word_t                         ctl0,
  input  cl_pkg::ch_vec_t                           ddr_is_ready,
  input  logic                                      flr_assert,
  input  cl_pkg::scrb_state_t [cl_pkg::NUM_DDR-1:0] scrb_state,
  input  cl_pkg::scrb_addr_t  [cl_pkg::NUM_DDR-1:0] scrb_addr,
  input  cl_pkg::ch_vec_t                           scrb_done,
  output cl_pkg::ch_vec_t                           scrub_en,
  output cl_pkg::ch_vec_t                           ddr_ready_q,
  output logic                                      flr_done,
  output cl_pkg::status_word_t                      status0,
  output cl_pkg::status_word_t                      id0,
  output cl_pkg::status_word_t                      id1
);

  import cl_pkg::*;

  localparam int SEL_W = $clog2(NUM_DDR);

  ctl_word_t            ctl_q;
  logic                 flr_assert_q;
  logic                 dbg_en;
  logic [2:0]           dbg_sel;
  logic [SEL_W-1:0]     sel_ch;
  scrb_addr_t           sel_addr;
  status_word_t         status_normal;
  status_word_t         status_debug;

  // --------------------------------------------------
  // Control register and ready capture
  // --------------------------------------------------
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      ctl_q       <= '0;
      ddr_ready_q <= '0;
    end
    else
    begin
      ctl_q       <= ctl0;
      ddr_ready_q <= ddr_is_ready;
    end
  end

  // Bits 3:0 enable the scrub engine of channels 3 to 0
  assign scrub_en = ctl_q[NUM_DDR-1:0];
  assign dbg_en   = ctl_q[CTL_DBG_EN_BIT];
  assign dbg_sel  = ctl_q[CTL_DBG_SEL_HI:CTL_DBG_SEL_LO];

  // Out-of-range selects fall back to channel 0
  assign sel_ch   = (dbg_sel < 3'(NUM_DDR)) ? dbg_sel[SEL_W-1:0] : '0;
  assign sel_addr = scrb_addr[sel_ch];

  // --------------------------------------------------
  // Status word
  // --------------------------------------------------
  // HMC done and link-up fields read as zero
  assign status_normal = {STATUS_SIG, 4'd0, scrb_done, ddr_ready_q};

  assign status_debug = {1'b0, scrb_state[3],
                         1'b0, scrb_state[2],
                         1'b0, scrb_state[1],
                         1'b0, scrb_state[0],
                         8'd0, scrb_done, ddr_ready_q};

  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      status0 <= '0;
      id0     <= '0;
      id1     <= '0;
    end
    else
    begin
      status0 <= dbg_en ? status_debug : status_normal;
      id0     <= dbg_en ? sel_addr[31:0]  : ID0_VALUE;
      id1     <= dbg_en ? sel_addr[63:32] : ID1_VALUE;
    end
  end

  // --------------------------------------------------
  // FLR response
  // --------------------------------------------------
  // Single-cycle acknowledge, toggles if the request stays high
  always_ff @(posedge clk or negedge sync_rst_n)
  begin
    if (!sync_rst_n)
    begin
      flr_assert_q <= 1'b0;
      flr_done     <= 1'b0;
    end
    else
    begin
      flr_assert_q <= flr_assert;
      flr_done     <= flr_assert_q && !flr_done;
    end
  end

endmodule

// File: cl_shell_ctrl.sv
// CL control and status shell, top level
// Connects the control/status block to one scrub engine per DDR channel
module cl_shell_ctrl (
  input  logic                 clk,
  input  logic                 sync_rst_n,
  input  cl_pkg::ctl_word_t    ctl0,
  input  cl_pkg::ch_vec_t      ddr_is_ready,
  input  logic                 flr_assert,
  output logic                 flr_done,
  output cl_pkg::status_word_t status0,
  output cl_pkg::status_word_t id0,
  output cl_pkg::status_word_t id1
);

  import cl_pkg::*;

  ch_vec_t                   scrub_en;
  ch_vec_t                   ddr_ready_q;
  scrb_state_t [NUM_DDR-1:0] scrb_state;
  scrb_addr_t  [NUM_DDR-1:0] scrb_addr;
  ch_vec_t                   scrb_done;

  // --------------------------------------------------
  // Control register, status and FLR
  // --------------------------------------------------
  ctrl_status i_ctrl_status (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .ddr_is_ready (ddr_is_ready),
    .flr_assert   (flr_assert),
    .scrb_state   (scrb_state),
    .scrb_addr    (scrb_addr),
    .scrb_done    (scrb_done),
    .scrub_en     (scrub_en),
    .ddr_ready_q  (ddr_ready_q),
    .flr_done     (flr_done),
    .status0      (status0),
    .id0          (id0),
    .id1          (id1)
  );

  // --------------------------------------------------
  // Per-channel scrub engines
  // --------------------------------------------------
  // Channel n uses bit n of every vector
  for (genvar ch = 0; ch < NUM_DDR; ch++)
  begin : g_scrub
    scrub_engine i_scrub_engine (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .enable     (scrub_en[ch]),
      .ddr_ready  (ddr_ready_q[ch]),
      .state      (scrb_state[ch]),
      .addr       (scrb_addr[ch]),
      .done       (scrb_done[ch])
    );
  end

endmodule

// File: scrub_engine_props.sv
// Assertions for the scrub engine
// Done only at the region end after a run, the address stays in the region
// and steps by one beat
module scrub_engine_props (
  input logic                clk,
  input logic                sync_rst_n,
  input logic                enable,
  input cl_pkg::scrb_state_t state,
  input cl_pkg::scrb_addr_t  addr,
  input logic                done
);

  import cl_pkg::*;

  // Done is entered from a run that reached the end, then held
  p_done_at_end: assert property (@(posedge clk) disable iff (!sync_rst_n)
    done |-> (addr == SCRB_END_ADDR) &&
             ($past(state) == SCRB_RUN || $past(state) == SCRB_DONE))
  else
    $error("done without a finished run at the end of the region");

  p_addr_in_region: assert property (@(posedge clk) disable iff (!sync_rst_n)
    addr <= SCRB_END_ADDR)
  else
    $error("scrub address past the end of the region");

  // The address update follows the enable seen one edge earlier
  p_addr_step: assert property (@(posedge clk) disable iff (!sync_rst_n)
    $past(enable) |-> (addr == $past(addr)) || (addr == $past(addr) + SCRB_BEAT_BYTES))
  else
    $error("scrub address moved by more than one beat");

endmodule

bind scrub_engine scrub_engine_props i_scrub_engine_props (
  .clk        (clk),
  .sync_rst_n (sync_rst_n),
  .enable     (enable),
  .state      (state),
  .addr       (addr),
  .done       (done)
);

// File: tb_cl_shell_ctrl.sv
// Directed testbench for the CL control and status shell
// Covers reset values, FLR acknowledge, ready capture and the scrub engines
module tb_cl_shell_ctrl;

  import cl_pkg::*;

  // Four full scrubs per test plus margin
  localparam int SCRUB_CYCLES = 140;
  localparam int NUM_TESTS    = 6;
  localparam int CYCLE_LIMIT  = NUM_TESTS * 4 * SCRUB_CYCLES + 640;
  localparam int DRIVE_DELAY  = 2;

  logic         clk;
  logic         sync_rst_n;
  ctl_word_t    ctl0;
  ch_vec_t      ddr_is_ready;
  logic         flr_assert;
  logic         flr_done;
  status_word_t status0;
  status_word_t id0;
  status_word_t id1;

  int     errors;
  int     checks;
  int     cycle_count;
  integer seed;

  cl_shell_ctrl i_dut (
    .clk          (clk),
    .sync_rst_n   (sync_rst_n),
    .ctl0         (ctl0),
    .ddr_is_ready (ddr_is_ready),
    .flr_assert   (flr_assert),
    .flr_done     (flr_done),
    .status0      (status0),
    .id0          (id0),
    .id1          (id1)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------
  // Inputs change and outputs are sampled a short delay after the edge
  task automatic next_cycle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  function automatic ctl_word_t make_ctl(input logic dbg, input int sel, input ch_vec_t en);
    ctl_word_t w;
    w = '0;
    w[CTL_DBG_EN_BIT] = dbg;
    w[CTL_DBG_SEL_HI:CTL_DBG_SEL_LO] = 3'(sel);
    w[NUM_DDR-1:0] = en;
    return w;
  endfunction

  function automatic scrb_state_t debug_state(input int ch);
    return scrb_state_t'(status0[16 + 4 * ch +: 3]);
  endfunction

  task automatic check_status(input string name, input status_word_t got,
                              input status_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input scrb_state_t got,
                             input scrb_state_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wait_done(input int ch, input int max_cycles);
    int n;
    n = 0;
    while (status0[4 + ch] !== 1'b1 && n < max_cycles)
    begin
      next_cycle(1);
      n++;
    end
    if (status0[4 + ch] !== 1'b1)
    begin
      errors++;
      $display("Channel %0d did not report done within %0d cycles", ch, max_cycles);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_values();
    next_cycle(2);
    check_status("status0", status0, {STATUS_SIG, 12'h000});
    check_status("id0", id0, ID0_VALUE);
    check_status("id1", id1, ID1_VALUE);
    check_bit("flr_done", flr_done, 1'b0);
  endtask

  task automatic test_flr_pulse();
    flr_assert = 1'b1;
    next_cycle(1);
    flr_assert = 1'b0;
    check_bit("flr_done", flr_done, 1'b0);
    next_cycle(1);
    check_bit("flr_done", flr_done, 1'b1);
    next_cycle(1);
    check_bit("flr_done", flr_done, 1'b0);
  endtask

  task automatic test_ready_capture();
    ch_vec_t pattern;
    ch_vec_t prev;
    prev = ddr_is_ready;
    for (int i = 0; i < 4; i++)
    begin
      pattern = ch_vec_t'($random(seed));
      // A new pattern every time, so the capture delay is visible
      if (pattern == prev)
        pattern = ~prev;
      ddr_is_ready = pattern;
      next_cycle(1);
      check_status("status0", status0, {STATUS_SIG, 8'h00, prev});
      next_cycle(1);
      check_status("status0", status0, {STATUS_SIG, 8'h00, pattern});
      prev = pattern;
    end
  endtask

  task automatic test_scrub_done(input int ch);
    status_word_t exp;
    ddr_is_ready = '1;
    ctl0 = make_ctl(1'b0, 0, ch_vec_t'(1 << ch));
    wait_done(ch, 4 * SCRUB_CYCLES);
    ctl0 = make_ctl(1'b1, ch, ch_vec_t'(1 << ch));
    next_cycle(2);
    exp = '0;
    exp[16 + 4 * ch +: 3] = SCRB_DONE;
    exp[4 + ch] = 1'b1;
    exp[3:0] = '1;
    check_status("status0", status0, exp);
    check_state("status0 state field", debug_state(ch), SCRB_DONE);
    check_status("id0", id0, SCRB_END_ADDR[31:0]);
    check_status("id1", id1, SCRB_END_ADDR[63:32]);
  endtask

  task automatic test_scrub_stall(input int ch);
    ddr_is_ready = ~ch_vec_t'(1 << ch);
    ctl0 = make_ctl(1'b1, ch, ch_vec_t'(1 << ch));
    next_cycle(200);
    check_bit("status0 done bit", status0[4 + ch], 1'b0);
    check_state("status0 state field", debug_state(ch), SCRB_RUN);
    // No beat taken, so the address is still at the start of the region
    check_status("id0", id0, 32'h0);
    check_status("id1", id1, 32'h0);
    ddr_is_ready = '1;
    wait_done(ch, 4 * SCRUB_CYCLES);
    check_state("status0 state field", debug_state(ch), SCRB_DONE);
  endtask

  task automatic test_scrub_clear(input int ch);
    ctl0 = make_ctl(1'b1, ch, '0);
    // Control register, engine restart, then status assembly
    next_cycle(3);
    check_bit("status0 done bit", status0[4 + ch], 1'b0);
    check_state("status0 state field", debug_state(ch), SCRB_IDLE);
    check_status("id0", id0, 32'h0);
    check_status("id1", id1, 32'h0);
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles before all tests finished", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    errors       = 0;
    checks       = 0;
    seed         = 32'h638a98d0;
    sync_rst_n   = 1'b0;
    ctl0         = '0;
    ddr_is_ready = '0;
    flr_assert   = 1'b0;

    repeat (8) @(posedge clk);
    #DRIVE_DELAY;
    sync_rst_n = 1'b1;

    test_reset_values();
    test_flr_pulse();
    test_ready_capture();
    test_scrub_done(2);
    test_scrub_stall(1);
    test_scrub_clear(1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: sim.f
cl_pkg.sv
scrub_engine.sv
ctrl_status.sv
cl_shell_ctrl.sv
scrub_engine_props.sv
tb_cl_shell_ctrl.sv

// File: Makefile
TOP := tb_cl_shell_ctrl

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
